// File: run_sim.sh
#!/bin/sh
# build and run the tsn_dgcl testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_tsn_dgcl --Mdir "$OBJ_DIR" -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ_DIR/Vtb_tsn_dgcl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: src/burst_capture.sv
`default_nettype none

module burst_capture (
	input logic fpu_clk,
	input logic reset,
	input fpu_port_pkg::dma_wr_req_t dma_in [fpu_port_pkg::NUM_PORTS],
	input logic [fpu_port_pkg::NUM_PORTS-1:0] grant,
	input logic fifo_full,
	output fpu_port_pkg::dma_wr_rsp_t dma_out [fpu_port_pkg::NUM_PORTS],
	output logic push,
	output dgcl_pkg::beat_t push_data,
	output logic burst_done
);

	import dgcl_pkg::*;
	import fpu_port_pkg::*;

	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_HDR, // resp high, waiting for the header beat
		CAP_DATA,
		CAP_DONE
	} cap_state_t;

	cap_state_t state;
	len_t beats_left;
	dma_wr_req_t sel; // granted requester
	header_t hdr;
	logic capturing;
	logic accept;

	//////////////////// port mux
	always_comb begin
		sel = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (grant[i])
				sel = dma_in[i];
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			dma_out[i].resp = grant[i] && (state == CAP_HDR);
			dma_out[i].write_ready = grant[i] && capturing && !fifo_full;
		end
	end

	assign capturing = (state == CAP_HDR) || (state == CAP_DATA);
	assign accept = capturing && sel.write_valid && !fifo_full;
	assign hdr = sel.write_data;

	assign push = accept; // every accepted beat goes to the beat FIFO
	assign push_data = sel.write_data;
	assign burst_done = (state == CAP_DONE);

	//////////////////// burst FSM
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= CAP_IDLE;
			beats_left <= '0;
		end else begin
			case (state)
				CAP_IDLE: begin
					if (grant != '0)
						state <= CAP_HDR;
				end
				CAP_HDR: begin
					if (accept) begin
						// only writes carry data beats
						if (hdr.mess_form == FORM_WRITE_CMD && hdr.cmd.length != '0) begin
							beats_left <= hdr.cmd.length;
							state <= CAP_DATA;
						end else begin
							state <= CAP_DONE;
						end
					end
				end
				CAP_DATA: begin
					if (accept) begin
						beats_left <= beats_left - 1'b1;
						if (beats_left == len_t'(1))
							state <= CAP_DONE; // last data beat
					end
				end
				default: state <= CAP_IDLE; // done pulse lasts one cycle
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/command_dispatch.sv
`default_nettype none

module command_dispatch #(
	parameter int CMD_FIFO_DEPTH = 4
) (
	input logic fpu_clk,
	input logic reset,
	input logic beat_empty,
	input dgcl_pkg::beat_t beat_data,
	input logic wr_data_full,
	output logic beat_pop,
	output logic wr_data_push,
	output dgcl_pkg::beat_t wr_data,
	output dgcl_pkg::dram_cmd_t rd_cmd,
	output logic rd_cmd_push,
	output dgcl_pkg::dram_cmd_t wr_cmd,
	output logic wr_cmd_push,
	input logic rd_cmd_full,
	input logic wr_cmd_full
);

	import dgcl_pkg::*;

	// command FIFO pointers wrap on a power of two
	if (CMD_FIFO_DEPTH < 2 || (CMD_FIFO_DEPTH & (CMD_FIFO_DEPTH - 1)) != 0) begin : g_depth_check
		$error("command FIFO depth must be a power of two of at least 2");
	end

	typedef enum logic {
		DSP_HDR,
		DSP_DATA // forwarding write data beats
	} dsp_state_t;

	dsp_state_t state;
	len_t beats_left;
	header_t hdr;
	logic is_read;
	logic is_write;
	logic move;

	assign hdr = beat_data; // head of the beat FIFO seen as a header
	assign is_read = (hdr.mess_form == FORM_READ_CMD);
	assign is_write = (hdr.mess_form == FORM_WRITE_CMD) && (hdr.cmd.length != '0);

	assign rd_cmd = hdr.cmd;
	assign wr_cmd = hdr.cmd;
	assign wr_data = beat_data;

	assign rd_cmd_push = (state == DSP_HDR) && !beat_empty && is_read && !rd_cmd_full;
	assign wr_cmd_push = (state == DSP_HDR) && !beat_empty && is_write && !wr_cmd_full;
	assign move = (state == DSP_DATA) && !beat_empty && !wr_data_full;
	assign wr_data_push = move;

	//////////////////// pop decision
	always_comb begin
		if (state == DSP_DATA)
			beat_pop = move;
		else if (beat_empty)
			beat_pop = 1'b0;
		else if (is_read)
			beat_pop = !rd_cmd_full; // wait for room in the read queue
		else if (is_write)
			beat_pop = !wr_cmd_full;
		else
			beat_pop = 1'b1; // unknown form or empty write, dropped
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			state <= DSP_HDR;
			beats_left <= '0;
		end else begin
			case (state)
				DSP_HDR: begin
					if (wr_cmd_push) begin
						beats_left <= hdr.cmd.length;
						state <= DSP_DATA;
					end
				end
				default: begin
					if (move) begin
						beats_left <= beats_left - 1'b1;
						if (beats_left == len_t'(1))
							state <= DSP_HDR; // final beat of the burst
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/dgcl_pkg.sv
`default_nettype none

package dgcl_pkg;

	//////////////////// beat and field widths
	localparam int BEAT_W = 128;
	localparam int LEN_W = 16;

	typedef logic [BEAT_W-1:0] beat_t; // one DMA beat
	typedef logic [LEN_W-1:0] len_t; // data beat count

	//////////////////// message forms
	localparam logic [7:0] FORM_READ_CMD = 8'h01;
	localparam logic [7:0] FORM_WRITE_CMD = 8'h03;

	// dram_addr sits at bit 0, length at the top
	typedef struct packed {
		len_t length; // data beats after the header
		logic [15:0] dpram_addr;
		logic [39:0] dram_addr;
	} dram_cmd_t;

	// overlay of a header beat
	typedef struct packed {
		logic [47:0] reserved;
		logic [7:0] mess_form; // bits 79:72
		dram_cmd_t cmd; // bits 71:0
	} header_t;

endpackage

`default_nettype wire

// File: src/dram_request_port.sv
`default_nettype none

module dram_request_port #(
	parameter int BEAT_FIFO_DEPTH = 16,
	parameter int CMD_FIFO_DEPTH = 4
) (
	input logic fpu_clk,
	input logic reset,
	input dgcl_pkg::dram_cmd_t rd_cmd,
	input logic rd_cmd_push,
	input dgcl_pkg::dram_cmd_t wr_cmd,
	input logic wr_cmd_push,
	input dgcl_pkg::beat_t wr_data,
	input logic wr_data_push,
	input logic rcc_ready,
	input logic wcc_ready,
	output logic rd_cmd_full,
	output logic wr_cmd_full,
	output logic wr_data_full,
	output dgcl_pkg::dram_cmd_t rcc_cmd,
	output logic rcc_valid,
	output dgcl_pkg::dram_cmd_t wcc_cmd,
	output dgcl_pkg::beat_t wcc_write_data,
	output logic wcc_valid
);

	import dgcl_pkg::*;

	logic rd_empty;
	dram_cmd_t wr_head;
	logic wc_empty;
	logic wc_pop;
	logic wd_empty;
	logic wd_pop;
	logic streaming; // a write command is latched
	len_t beats_left;

	sync_fifo #(.DEPTH(CMD_FIFO_DEPTH), .payload_t(dram_cmd_t)) u_rd_cmd_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.push(rd_cmd_push), .push_data(rd_cmd), .pop(rcc_valid),
		.pop_data(rcc_cmd), .full(rd_cmd_full), .empty(rd_empty)
	);

	sync_fifo #(.DEPTH(CMD_FIFO_DEPTH), .payload_t(dram_cmd_t)) u_wr_cmd_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.push(wr_cmd_push), .push_data(wr_cmd), .pop(wc_pop),
		.pop_data(wr_head), .full(wr_cmd_full), .empty(wc_empty)
	);

	sync_fifo #(.DEPTH(BEAT_FIFO_DEPTH), .payload_t(beat_t)) u_wr_data_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.push(wr_data_push), .push_data(wr_data), .pop(wd_pop),
		.pop_data(wcc_write_data), .full(wr_data_full), .empty(wd_empty)
	);

	assign rcc_valid = !rd_empty && rcc_ready; // command is taken this cycle

	//////////////////// write stream
	assign wc_pop = !streaming && !wc_empty;
	assign wcc_valid = streaming && !wd_empty;
	assign wd_pop = wcc_valid && wcc_ready;

	always_ff @(posedge fpu_clk) begin
		if (wc_pop)
			wcc_cmd <= wr_head; // held for the whole burst
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			streaming <= 1'b0;
			beats_left <= '0;
		end else if (wc_pop) begin
			streaming <= 1'b1;
			beats_left <= wr_head.length;
		end else if (wd_pop) begin
			beats_left <= beats_left - 1'b1;
			if (beats_left == len_t'(1))
				streaming <= 1'b0;
		end
	end

	a_valid_has_data: assert property (@(posedge fpu_clk) disable iff (reset)
		$rose(wcc_valid) |-> !wd_empty);

endmodule

`default_nettype wire

// File: src/fpu_port_pkg.sv
`default_nettype none

package fpu_port_pkg;

	//////////////////// requester count
	localparam int NUM_PORTS = 4; // ports a..d

	typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

	//////////////////// requester side
	// driven by one FPU DMA requester
	typedef struct packed {
		logic req; // held until granted
		logic write_valid;
		dgcl_pkg::beat_t write_data;
	} dma_wr_req_t;

	// back to the requester
	typedef struct packed {
		logic resp; // gateway waits for the header
		logic write_ready;
	} dma_wr_rsp_t;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 16,
	parameter type payload_t = logic [7:0]
) (
	input logic fpu_clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic full,
	output logic empty
);

	localparam int PTR_W = $clog2(DEPTH);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count; // one extra bit so DEPTH fits
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == (PTR_W+1)'(DEPTH));
	assign empty = (count == '0);
	assign pop_data = mem[rd_ptr]; // head word shows without a pop

	always_ff @(posedge fpu_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// producers and consumers elsewhere must respect full / empty
	a_no_overflow: assert property (@(posedge fpu_clk) disable iff (reset) !(push && full));
	a_no_underflow: assert property (@(posedge fpu_clk) disable iff (reset) !(pop && empty));

endmodule

`default_nettype wire

// File: src/token_arbiter.sv
`default_nettype none

module token_arbiter (
	input logic fpu_clk,
	input logic reset,
	input logic [fpu_port_pkg::NUM_PORTS-1:0] req,
	input logic burst_done,
	output logic [fpu_port_pkg::NUM_PORTS-1:0] grant
);

	import fpu_port_pkg::*;

	port_idx_t last_idx; // port that held the token last
	port_idx_t next_idx;
	logic found;

	//////////////////// round-robin search
	// starts one past the last grant and wraps
	always_comb begin
		next_idx = last_idx;
		found = 1'b0;
		for (int i = 1; i <= NUM_PORTS; i++) begin
			if (!found && req[port_idx_t'((int'(last_idx) + i) % NUM_PORTS)]) begin
				next_idx = port_idx_t'((int'(last_idx) + i) % NUM_PORTS);
				found = 1'b1;
			end
		end
	end

	//////////////////// token register
	always_ff @(posedge fpu_clk or posedge reset) begin
		if (reset) begin
			grant <= '0;
			last_idx <= port_idx_t'(NUM_PORTS - 1); // so port a goes first
		end else if (grant == '0) begin
			if (found) begin
				grant <= NUM_PORTS'(1) << next_idx;
				last_idx <= next_idx;
			end
		end else if (burst_done) begin
			grant <= '0; // token back, one idle cycle before the next grant
		end
	end

	a_grant_onehot: assert property (@(posedge fpu_clk) disable iff (reset)
		$onehot0(grant));

endmodule

`default_nettype wire

// File: src/tsn_dgcl.sv
`default_nettype none

module tsn_dgcl #(
	parameter int BEAT_FIFO_DEPTH = 16,
	parameter int CMD_FIFO_DEPTH = 4
) (
	input logic fpu_clk,
	input logic reset,
	input fpu_port_pkg::dma_wr_req_t dma_in [fpu_port_pkg::NUM_PORTS],
	output fpu_port_pkg::dma_wr_rsp_t dma_out [fpu_port_pkg::NUM_PORTS],
	output dgcl_pkg::dram_cmd_t rcc_cmd,
	output logic rcc_valid,
	input logic rcc_ready,
	output dgcl_pkg::dram_cmd_t wcc_cmd,
	output dgcl_pkg::beat_t wcc_write_data,
	output logic wcc_valid,
	input logic wcc_ready
);

	import dgcl_pkg::*;
	import fpu_port_pkg::*;

	logic [NUM_PORTS-1:0] req;
	logic [NUM_PORTS-1:0] grant;
	logic burst_done;
	logic beat_push;
	beat_t beat_push_data;
	logic beat_full;
	logic beat_pop;
	beat_t beat_data;
	logic beat_empty;
	dram_cmd_t rd_cmd;
	logic rd_cmd_push;
	logic rd_cmd_full;
	dram_cmd_t wr_cmd;
	logic wr_cmd_push;
	logic wr_cmd_full;
	beat_t wr_data;
	logic wr_data_push;
	logic wr_data_full;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++)
			req[i] = dma_in[i].req;
	end

	//////////////////// requester side
	token_arbiter u_arbiter (
		.fpu_clk(fpu_clk), .reset(reset), .req(req),
		.burst_done(burst_done), .grant(grant)
	);

	burst_capture u_capture (
		.fpu_clk(fpu_clk), .reset(reset), .dma_in(dma_in), .grant(grant),
		.fifo_full(beat_full), .dma_out(dma_out), .push(beat_push),
		.push_data(beat_push_data), .burst_done(burst_done)
	);

	sync_fifo #(.DEPTH(BEAT_FIFO_DEPTH), .payload_t(beat_t)) u_beat_fifo (
		.fpu_clk(fpu_clk), .reset(reset),
		.push(beat_push), .push_data(beat_push_data), .pop(beat_pop),
		.pop_data(beat_data), .full(beat_full), .empty(beat_empty)
	);

	//////////////////// DRAM side
	command_dispatch #(.CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)) u_dispatch (
		.fpu_clk(fpu_clk), .reset(reset), .beat_empty(beat_empty),
		.beat_data(beat_data), .wr_data_full(wr_data_full), .beat_pop(beat_pop),
		.wr_data_push(wr_data_push), .wr_data(wr_data),
		.rd_cmd(rd_cmd), .rd_cmd_push(rd_cmd_push),
		.wr_cmd(wr_cmd), .wr_cmd_push(wr_cmd_push),
		.rd_cmd_full(rd_cmd_full), .wr_cmd_full(wr_cmd_full)
	);

	dram_request_port #(
		.BEAT_FIFO_DEPTH(BEAT_FIFO_DEPTH),
		.CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
	) u_dram_port (
		.fpu_clk(fpu_clk), .reset(reset),
		.rd_cmd(rd_cmd), .rd_cmd_push(rd_cmd_push),
		.wr_cmd(wr_cmd), .wr_cmd_push(wr_cmd_push),
		.wr_data(wr_data), .wr_data_push(wr_data_push),
		.rcc_ready(rcc_ready), .wcc_ready(wcc_ready),
		.rd_cmd_full(rd_cmd_full), .wr_cmd_full(wr_cmd_full),
		.wr_data_full(wr_data_full), .rcc_cmd(rcc_cmd), .rcc_valid(rcc_valid),
		.wcc_cmd(wcc_cmd), .wcc_write_data(wcc_write_data), .wcc_valid(wcc_valid)
	);

endmodule

`default_nettype wire

// File: testbench/tb_tsn_dgcl.sv
`default_nettype none

module tb_tsn_dgcl;

	import dgcl_pkg::*;
	import fpu_port_pkg::*;

	localparam port_idx_t PORT_A = 2'd0;
	localparam port_idx_t PORT_B = 2'd1;
	localparam port_idx_t PORT_C = 2'd2;
	localparam port_idx_t PORT_D = 2'd3;
	localparam int BP_LEN_A = 20;
	localparam int BP_LEN_B = 40;
	localparam int BP_LEN_D = 7;
	// header and data beats of all tests together
	localparam int TOTAL_BEATS = 1 + 6 + 7 + (BP_LEN_A + BP_LEN_B + BP_LEN_D + 5) + 3;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40;
	localparam int DRAIN_LIMIT = 500;

	logic fpu_clk;
	logic reset;
	dma_wr_req_t dma_in [NUM_PORTS];
	dma_wr_rsp_t dma_out [NUM_PORTS];
	dram_cmd_t rcc_cmd;
	logic rcc_valid;
	logic rcc_ready;
	dram_cmd_t wcc_cmd;
	beat_t wcc_write_data;
	logic wcc_valid;
	logic wcc_ready;

	beat_t burst_q [NUM_PORTS][$]; // next burst of each requester
	dram_cmd_t exp_rd[$];
	dram_cmd_t exp_wcmd[$];
	beat_t exp_beat[$];
	dram_cmd_t cur_wcmd; // write command of the beats now streaming
	dram_cmd_t mon_cmd;
	beat_t mon_beat;
	int wr_left;
	logic [15:0] data_lfsr;
	logic [15:0] ready_lfsr;
	logic bp_mode;
	int stall_cycles;
	string cur_test;
	int errors;
	int err_at_start;
	int tests_run;
	int tests_failed;

	tsn_dgcl #(.BEAT_FIFO_DEPTH(16), .CMD_FIFO_DEPTH(4)) uut (
		.fpu_clk(fpu_clk), .reset(reset), .dma_in(dma_in), .dma_out(dma_out),
		.rcc_cmd(rcc_cmd), .rcc_valid(rcc_valid), .rcc_ready(rcc_ready),
		.wcc_cmd(wcc_cmd), .wcc_write_data(wcc_write_data),
		.wcc_valid(wcc_valid), .wcc_ready(wcc_ready)
	);

	always #10 fpu_clk = ~fpu_clk;

	//////////////////// stimulus helpers
	// fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic beat_t rand_beat();
		beat_t b;
		b = '0;
		for (int i = 0; i < BEAT_W; i++) begin
			data_lfsr = lfsr_next(data_lfsr);
			b = {b[BEAT_W-2:0], data_lfsr[0]};
		end
		return b;
	endfunction

	// bus layout: dram_addr 39:0, dpram_addr 55:40, length 71:56, form 79:72
	function automatic beat_t make_header(input logic [7:0] form, input logic [39:0] dram_addr,
			input logic [15:0] dpram_addr, input logic [15:0] length);
		beat_t b;
		b = '0;
		b[39:0] = dram_addr;
		b[55:40] = dpram_addr;
		b[71:56] = length;
		b[79:72] = form;
		b[127:80] = 48'h5a5a_c3c3_0ff0; // reserved, ignored by the gateway
		return b;
	endfunction

	function automatic dram_cmd_t make_cmd(input logic [39:0] dram_addr,
			input logic [15:0] dpram_addr, input logic [15:0] length);
		dram_cmd_t c;
		c.dram_addr = dram_addr;
		c.dpram_addr = dpram_addr;
		c.length = length;
		return c;
	endfunction

	task automatic queue_read(input port_idx_t p, input logic [39:0] dram_addr,
			input logic [15:0] dpram_addr);
		burst_q[p].push_back(make_header(FORM_READ_CMD, dram_addr, dpram_addr, 16'd8));
		exp_rd.push_back(make_cmd(dram_addr, dpram_addr, 16'd8));
	endtask

	task automatic queue_write(input port_idx_t p, input logic [39:0] dram_addr,
			input logic [15:0] dpram_addr, input int len);
		beat_t b;
		burst_q[p].push_back(make_header(FORM_WRITE_CMD, dram_addr, dpram_addr, 16'(len)));
		exp_wcmd.push_back(make_cmd(dram_addr, dpram_addr, 16'(len)));
		for (int i = 0; i < len; i++) begin
			b = rand_beat();
			burst_q[p].push_back(b);
			exp_beat.push_back(b);
		end
	endtask

	// header only, nothing may come out for it
	task automatic queue_drop(input port_idx_t p, input logic [7:0] form,
			input logic [15:0] length);
		burst_q[p].push_back(make_header(form, 40'h00_dead_0000, 16'h0, length));
	endtask

	// one requester: req, wait for resp, then one beat per write_ready
	task automatic send_burst(input port_idx_t p);
		beat_t b;
		@(negedge fpu_clk);
		dma_in[p].req = 1'b1;
		@(posedge fpu_clk);
		while (!dma_out[p].resp)
			@(posedge fpu_clk);
		while (burst_q[p].size() > 0) begin
			b = burst_q[p].pop_front();
			@(negedge fpu_clk);
			dma_in[p].write_valid = 1'b1;
			dma_in[p].write_data = b;
			@(posedge fpu_clk);
			while (!dma_out[p].write_ready) begin
				stall_cycles++; // beat FIFO full
				@(posedge fpu_clk);
			end
		end
		@(negedge fpu_clk);
		dma_in[p].write_valid = 1'b0;
		dma_in[p].req = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((exp_rd.size() != 0 || exp_beat.size() != 0) && cycles < DRAIN_LIMIT) begin
			@(posedge fpu_clk);
			cycles++;
		end
		if (exp_rd.size() != 0 || exp_beat.size() != 0) begin
			$display("[%s] outputs stalled with %0d read commands and %0d beats missing",
				cur_test, exp_rd.size(), exp_beat.size());
			errors++;
		end
		repeat (2) @(posedge fpu_clk);
	endtask

	task automatic test_start(input string name);
		cur_test = name;
		err_at_start = errors;
	endtask

	task automatic test_end();
		tests_run++;
		if (errors != err_at_start) begin
			tests_failed++;
			$display("%s: failed with %0d errors", cur_test, errors - err_at_start);
		end else begin
			$display("%s: passed", cur_test);
		end
	endtask

	//////////////////// DRAM side
	always @(negedge fpu_clk) begin
		if (bp_mode) begin
			ready_lfsr = lfsr_next(ready_lfsr);
			wcc_ready = ready_lfsr[0];
			ready_lfsr = lfsr_next(ready_lfsr);
			wcc_ready = wcc_ready & ready_lfsr[0]; // about one cycle in four
			ready_lfsr = lfsr_next(ready_lfsr);
			rcc_ready = ready_lfsr[0];
		end else begin
			wcc_ready = 1'b1;
			rcc_ready = 1'b1;
		end
	end

	always @(posedge fpu_clk) begin
		if (!reset) begin
			if (rcc_valid) begin
				if (exp_rd.size() == 0) begin
					$display("[%s] read command %h came out with none expected", cur_test, rcc_cmd);
					errors++;
				end else begin
					mon_cmd = exp_rd.pop_front();
					if (rcc_cmd !== mon_cmd) begin
						$display("** Error [%s] rcc_cmd: expected %h, actual %h",
							cur_test, mon_cmd, rcc_cmd);
						errors++;
					end
				end
			end
			if (wcc_valid && exp_beat.size() == 0) begin
				$display("[%s] wcc_valid is high with no write beat expected", cur_test);
				errors++;
			end else if (wcc_valid && wcc_ready) begin
				if (wr_left == 0) begin
					cur_wcmd = exp_wcmd.pop_front(); // first beat of a new burst
					wr_left = int'(cur_wcmd.length);
				end
				if (wcc_cmd !== cur_wcmd) begin
					$display("** Error [%s] wcc_cmd: expected %h, actual %h",
						cur_test, cur_wcmd, wcc_cmd);
					errors++;
				end
				mon_beat = exp_beat.pop_front();
				if (wcc_write_data !== mon_beat) begin
					$display("** Error [%s] wcc_write_data: expected %h, actual %h",
						cur_test, mon_beat, wcc_write_data);
					errors++;
				end
				wr_left--;
			end
		end
	end

	//////////////////// tests
	task automatic test_reset_state();
		test_start("reset_state");
		@(posedge fpu_clk);
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (dma_out[i] !== '0) begin
				$display("** Error [%s] dma_out[%0d]: expected 0, actual %b",
					cur_test, i, dma_out[i]);
				errors++;
			end
		end
		if (rcc_valid !== 1'b0 || wcc_valid !== 1'b0) begin
			$display("** Error [%s] rcc_valid/wcc_valid: expected 00, actual %b%b",
				cur_test, rcc_valid, wcc_valid);
			errors++;
		end
		test_end();
	endtask

	task automatic test_read_cmd();
		test_start("read_cmd");
		queue_read(PORT_B, 40'h12_3456_789a, 16'h0abc);
		send_burst(PORT_B);
		wait_drain();
		test_end();
	endtask

	task automatic test_write_burst();
		test_start("write_burst");
		queue_write(PORT_C, 40'h80_0000_1000, 16'h0200, 5);
		send_burst(PORT_C);
		wait_drain();
		test_end();
	endtask

	task automatic test_round_robin();
		test_start("round_robin");
		queue_read(PORT_D, 40'h00_0000_00dd, 16'h0d00); // token last at port d
		send_burst(PORT_D);
		wait_drain();
		queue_read(PORT_A, 40'h00_0000_000a, 16'h0a00);
		queue_read(PORT_B, 40'h00_0000_000b, 16'h0b00);
		queue_read(PORT_C, 40'h00_0000_000c, 16'h0c00);
		queue_read(PORT_D, 40'h00_0000_000d, 16'h0d00);
		fork
			send_burst(PORT_A);
			send_burst(PORT_B);
			send_burst(PORT_C);
			send_burst(PORT_D);
		join
		wait_drain();
		queue_read(PORT_A, 40'h00_0000_01a0, 16'h0a01);
		queue_read(PORT_C, 40'h00_0000_01c0, 16'h0c01);
		fork
			send_burst(PORT_A);
			send_burst(PORT_C);
		join
		wait_drain();
		test_end();
	endtask

	task automatic test_back_pressure();
		test_start("back_pressure");
		stall_cycles = 0;
		bp_mode = 1'b1;
		queue_write(PORT_A, 40'h10_0000_0000, 16'h1000, BP_LEN_A);
		send_burst(PORT_A);
		queue_read(PORT_C, 40'h10_0000_0c00, 16'h1c00);
		send_burst(PORT_C);
		queue_write(PORT_B, 40'h20_0000_0000, 16'h2000, BP_LEN_B);
		send_burst(PORT_B);
		queue_write(PORT_D, 40'h30_0000_0000, 16'h3000, BP_LEN_D);
		send_burst(PORT_D);
		queue_read(PORT_C, 40'h10_0000_0c80, 16'h1c80);
		send_burst(PORT_C);
		wait_drain();
		bp_mode = 1'b0;
		if (stall_cycles == 0) begin
			$display("[%s] write_ready was never withheld, the beat FIFO never filled",
				cur_test);
			errors++;
		end
		test_end();
	endtask

	task automatic test_discard();
		test_start("discard");
		queue_drop(PORT_A, 8'h07, 16'd3);
		send_burst(PORT_A);
		queue_drop(PORT_B, FORM_WRITE_CMD, 16'd0); // write with no data
		send_burst(PORT_B);
		queue_read(PORT_C, 40'h55_0000_0040, 16'h0555);
		send_burst(PORT_C);
		wait_drain();
		test_end();
	endtask

	//////////////////// main
	initial begin
		fpu_clk = 1'b0;
		reset = 1'b1;
		rcc_ready = 1'b1;
		wcc_ready = 1'b1;
		for (int i = 0; i < NUM_PORTS; i++)
			dma_in[i] = '0;
		data_lfsr = 16'd39;
		ready_lfsr = 16'd39;
		bp_mode = 1'b0;
		stall_cycles = 0;
		wr_left = 0;
		errors = 0;
		err_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = "reset";
		repeat (2) @(posedge fpu_clk);
		@(negedge fpu_clk);
		reset = 1'b0;
		test_reset_state();
		test_read_cmd();
		test_write_burst();
		test_round_robin();
		test_back_pressure();
		test_discard();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fpu_clk);
		$display("watchdog ran out after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
src/dgcl_pkg.sv
src/fpu_port_pkg.sv
src/sync_fifo.sv
src/token_arbiter.sv
src/burst_capture.sv
src/command_dispatch.sv
src/dram_request_port.sv
src/tsn_dgcl.sv
testbench/tb_tsn_dgcl.sv
